/* dv/cache_patterns.txt */
# c|b name code addr(hex) rnd hit way l2_op  (c waits for its answer, b is sent back-to-back)
# s name d_reads d_writes d_hits d_misses i_reads i_hits i_misses  (decimal counters)
c rd_cold 0 00000040 0 0 0 1
c rd_hit 0 00000040 0 1 0 0
c wr_hit 1 00000040 0 1 0 0
c rd_t1 0 00000440 0 0 1 1
c rd_t2 0 00000840 0 0 2 1
c rd_t3 0 00000c40 0 0 3 1
c rd_t4 0 00001040 0 0 4 1
c rd_t5 0 00001440 0 0 5 1
c rd_t6 0 00001840 0 0 6 1
c rd_t7 0 00001c40 0 0 7 1
c rd_t8_evict 0 00002040 0 0 0 3
c rd_t1_touch 0 00000440 0 1 1 0
c rd_t9_evict 0 00002440 0 0 2 1
c if_cold 2 00000080 0 0 0 1
c if_hit 2 00000080 0 1 0 0
c if_t1 2 00000480 0 0 1 1
c if_t2 2 00000880 0 0 2 1
c if_t3 2 00000c80 0 0 3 1
c if_t4_evict 2 00001080 0 0 0 1
c wr_miss 1 000000c0 0 0 0 2
c snp_rd_m 4 000000c0 0 1 0 5
c wr_shared 1 000000c0 0 1 0 2
c rd_e 0 000004c0 0 0 1 1
c snp_inv_e 3 000004c0 0 1 1 0
c rd_after_inv 0 000004c0 0 0 1 1
c snp_absent 3 000008c0 0 0 0 0
c snp_rnd_inv 3 00000380 1 0 0 0
c snp_rnd_rd 4 00000380 1 0 0 0
c rd_rnd 0 00000340 1 0 0 1
c bad_code9 9 00000000 0 0 0 0
c bad_code5 5 00000000 0 0 0 0
s stats_mid 15 3 4 14 6 1 5
c clear 8 00000000 0 0 0 0
s stats_clear 0 0 0 0 0 0 0
c rd_after_clear 0 00002040 0 0 0 1
b burst_rd 0 00000140 0 0 0 1
b burst_wr 1 00000140 0 1 0 0
b burst_rd_t1 0 00000540 0 0 1 1
b burst_if 2 00000140 0 0 0 1
b burst_if_hit 2 00000140 0 1 0 0
b burst_snp 4 00000140 0 1 0 5
s stats_final 3 1 1 3 2 1 1

/* dv/tb_tasks.svh */
// drive, wait and compare tasks of the L1 split cache testbench
// included inside the testbench module, works on its signals and queues

function automatic logic valid_code(input int code);
    return (code <= 4) || (code == 8);
endfunction

function automatic cache_op_e op_for_code(input int code);
    case (code)
        1:       return OP_DWRITE;
        2:       return OP_IFETCH;
        3:       return OP_SNOOP_INV;
        4:       return OP_SNOOP_RD;
        8:       return OP_CLEAR;
        default: return OP_DREAD;
    endcase
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
    begin
        errors++;
        $display("Error: %s expected %0d actual %0d", name, expected, actual);
    end
endtask

// one strobe on the next falling edge once busy is low
task automatic send_cmd(input logic [3:0] code, input logic [ADDR_W-1:0] addr);
    int cycles;
    cycles = 0;
    @(negedge clk);
    cmd_valid = 1'b0;
    while (busy && cycles < TIMEOUT)
    begin
        @(negedge clk);
        cycles++;
    end
    if (busy)
    begin
        timeouts++;
        $display("Timeout while waiting for busy to drop");
    end
    else
    begin
        cmd_valid = 1'b1;
        cmd_code  = code;
        cmd_addr  = addr;
    end
endtask

// waits for every queued response and bad_cmd pulse, then checks them in order
task automatic wait_pending();
    int           cycles;
    access_resp_t act;
    access_resp_t exp_resp;
    string        tname;
    cycles = 0;
    @(negedge clk);
    cmd_valid = 1'b0;
    while ((resp_q.size() < exp_q.size() || bad_seen < bad_expected) && cycles < TIMEOUT)
    begin
        @(posedge clk);
        cycles++;
    end
    if (resp_q.size() < exp_q.size() || bad_seen < bad_expected)
    begin
        timeouts++;
        $display("Timeout while waiting for a response or a bad_cmd pulse");
    end
    else
    begin
        while (exp_q.size() != 0)
        begin
            act      = resp_q.pop_front();
            exp_resp = exp_q.pop_front();
            tname    = name_q.pop_front();
            check_value({tname, " op"}, 32'(exp_resp.op), 32'(act.op));
            check_value({tname, " hit"}, 32'(exp_resp.hit), 32'(act.hit));
            check_value({tname, " way"}, 32'(exp_resp.way), 32'(act.way));
            check_value({tname, " l2_op"}, 32'(exp_resp.l2_op), 32'(act.l2_op));
        end
    end
endtask

/* dv/tb_l1_split_cache.sv */
`timescale 1ns/10ps
// testbench of the L1 split cache, replays dv/cache_patterns.txt
// and checks each response and each counter snapshot listed there
module tb_l1_split_cache
    import cache_pkg::*;
;

    localparam int OFFSET_W = 6;
    localparam int INDEX_W  = 4;
    localparam int TIMEOUT  = 50000;

    logic              clk;
    logic              arst_n;
    logic              cmd_valid;
    logic [3:0]        cmd_code;
    logic [ADDR_W-1:0] cmd_addr;
    logic              busy;
    logic              bad_cmd;
    logic              resp_valid;
    access_resp_t      resp;
    cache_stats_t      stats;

    access_resp_t resp_q [$];
    access_resp_t exp_q [$];
    string        name_q [$];
    int           bad_seen;
    int           bad_expected;
    int           busy_cycles;
    int           errors;
    int           timeouts;
    int           seed;

    l1_split_cache #(
        .OFFSET_W (OFFSET_W),
        .INDEX_W  (INDEX_W)
    ) u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_code   (cmd_code),
        .cmd_addr   (cmd_addr),
        .busy       (busy),
        .bad_cmd    (bad_cmd),
        .resp_valid (resp_valid),
        .resp       (resp),
        .stats      (stats)
    );

    always #2 clk = ~clk;

    always @(negedge clk)
    begin
        if (resp_valid)
            resp_q.push_back(resp);     // mid-cycle sample
        if (bad_cmd)
            bad_seen++;
        if (busy)
            busy_cycles++;
    end

    `include "tb_tasks.svh"

    initial
    begin
        int           fd;
        int           n;
        string        line;
        string        kind;
        string        tname;
        int           code;
        logic [31:0]  addr;
        logic [31:0]  rnd_addr;
        int           rnd;
        int           hit;
        int           way;
        int           l2;
        int           cnt [7];
        access_resp_t exp_resp;
        cache_stats_t exp_stats;

        clk          = 1'b0;
        arst_n       = 1'b0;
        cmd_valid    = 1'b0;
        cmd_code     = '0;
        cmd_addr     = '0;
        bad_seen     = 0;
        bad_expected = 0;
        busy_cycles  = 0;
        errors       = 0;
        timeouts     = 0;
        seed         = 40;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        fd = $fopen("dv/cache_patterns.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the pattern file");
        end
        else
        begin
            while (!$feof(fd) && timeouts == 0)
            begin
                line = "";
                n    = $fgets(line, fd);
                if (n <= 1 || line.substr(0, 0) == "#")
                    continue;
                n = $sscanf(line, "%s", kind);
                if (kind == "s")
                begin
                    n = $sscanf(line, "%s %s %d %d %d %d %d %d %d", kind, tname,
                                cnt[0], cnt[1], cnt[2], cnt[3], cnt[4], cnt[5], cnt[6]);
                    wait_pending();
                    @(negedge clk);     // counters settle one cycle after the response
                    exp_stats = '{d_reads: cnt[0][15:0], d_writes: cnt[1][15:0],
                                  d_hits: cnt[2][15:0], d_misses: cnt[3][15:0],
                                  i_reads: cnt[4][15:0], i_hits: cnt[5][15:0],
                                  i_misses: cnt[6][15:0]};
                    check_value({tname, " d_reads"}, exp_stats.d_reads, stats.d_reads);
                    check_value({tname, " d_writes"}, exp_stats.d_writes, stats.d_writes);
                    check_value({tname, " d_hits"}, exp_stats.d_hits, stats.d_hits);
                    check_value({tname, " d_misses"}, exp_stats.d_misses, stats.d_misses);
                    check_value({tname, " i_reads"}, exp_stats.i_reads, stats.i_reads);
                    check_value({tname, " i_hits"}, exp_stats.i_hits, stats.i_hits);
                    check_value({tname, " i_misses"}, exp_stats.i_misses, stats.i_misses);
                    check_value({tname, " busy"}, 32'd0, 32'(busy));   // queue is drained
                end
                else
                begin
                    n = $sscanf(line, "%s %s %d %h %d %d %d %d", kind, tname, code, addr,
                                rnd, hit, way, l2);
                    if (rnd != 0)
                    begin
                        rnd_addr = $random(seed);   // new tag and offset, same set
                        addr = {rnd_addr[31:OFFSET_W+INDEX_W],
                                addr[OFFSET_W+INDEX_W-1:OFFSET_W],
                                rnd_addr[OFFSET_W-1:0]};
                    end
                    if (kind == "c" && exp_q.size() != 0)
                        wait_pending();
                    send_cmd(code[3:0], addr);
                    if (valid_code(code))
                    begin
                        exp_resp = '{op: op_for_code(code), hit: hit[0], way: way[2:0],
                                     l2_op: l2_op_e'(l2)};
                        exp_q.push_back(exp_resp);
                        name_q.push_back(tname);
                    end
                    else
                        bad_expected++;
                    if (kind == "c")
                        wait_pending();
                end
            end
            $fclose(fd);
            if (timeouts == 0)
            begin
                wait_pending();
                check_value("extra responses", 32'd0, 32'(resp_q.size()));
                check_value("bad_cmd pulses", 32'(bad_expected), 32'(bad_seen));
                // the back-to-back burst outruns the controller and fills the queue
                check_value("busy raised", 32'd1, 32'(busy_cycles != 0));
            end
        end

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* logic/cache_controller.sv */
`timescale 1ns/10ps
// tag and MESI store of the 8-way data cache and 4-way instruction cache
// pops one request, looks it up, then updates lines and answers with a response
module cache_controller
    import cache_pkg::*;
#(
    parameter int OFFSET_W = 6,
    parameter int INDEX_W  = 4,
    parameter int D_WAYS   = 8,
    parameter int I_WAYS   = 4
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  cache_req_t   head,
    input  logic         not_empty,
    output logic         pop,
    output logic         resp_valid,
    output access_resp_t resp,
    output cache_stats_t stats
);

    localparam int SETS    = 2 ** INDEX_W;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int D_WAY_W = $clog2(D_WAYS);
    localparam int I_WAY_W = $clog2(I_WAYS);

    typedef enum logic [1:0] {IDLE, LOOKUP, UPDATE, CLEAR} ctrl_state_e;

    ctrl_state_e        state;
    cache_req_t         req_q;
    logic [INDEX_W-1:0] clr_idx;
    logic [TAG_W-1:0]   d_tag [SETS][D_WAYS];
    mesi_e              d_st  [SETS][D_WAYS];
    logic [TAG_W-1:0]   i_tag [SETS][I_WAYS];
    mesi_e              i_st  [SETS][I_WAYS];
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic               d_hit;
    logic               d_free;
    logic               i_hit;
    logic               i_free;
    logic [D_WAY_W-1:0] d_hit_way;
    logic [D_WAY_W-1:0] d_free_way;
    logic [D_WAY_W-1:0] d_oldest;
    logic [D_WAY_W-1:0] d_way;
    logic [I_WAY_W-1:0] i_hit_way;
    logic [I_WAY_W-1:0] i_free_way;
    logic [I_WAY_W-1:0] i_oldest;
    logic [I_WAY_W-1:0] i_way;
    mesi_e              d_old;
    mesi_e              d_new;
    access_resp_t       lk_resp;
    logic               d_wr;
    logic               d_fill;
    logic               i_fill;
    logic               upd;
    logic               clr_start;

    assign idx        = req_q.addr[OFFSET_W +: INDEX_W];
    assign tag        = req_q.addr[ADDR_W-1 -: TAG_W];
    assign upd        = (state == UPDATE);
    assign pop        = (state == IDLE) && not_empty;
    assign resp_valid = upd;
    assign clr_start  = (state == CLEAR) && (clr_idx == '0);

    // tag compare and free-way search, lowest way wins
    always_comb
    begin
        d_hit      = 1'b0;
        d_free     = 1'b0;
        d_hit_way  = '0;
        d_free_way = '0;
        i_hit      = 1'b0;
        i_free     = 1'b0;
        i_hit_way  = '0;
        i_free_way = '0;
        for (int w = D_WAYS - 1; w >= 0; w--)
        begin
            if (d_st[idx][w] != ST_I && d_tag[idx][w] == tag)
            begin
                d_hit     = 1'b1;
                d_hit_way = D_WAY_W'(w);
            end
            if (d_st[idx][w] == ST_I)
            begin
                d_free     = 1'b1;
                d_free_way = D_WAY_W'(w);
            end
        end
        for (int w = I_WAYS - 1; w >= 0; w--)
        begin
            if (i_st[idx][w] != ST_I && i_tag[idx][w] == tag)
            begin
                i_hit     = 1'b1;
                i_hit_way = I_WAY_W'(w);
            end
            if (i_st[idx][w] == ST_I)
            begin
                i_free     = 1'b1;
                i_free_way = I_WAY_W'(w);
            end
        end
        d_way = d_hit ? d_hit_way : (d_free ? d_free_way : d_oldest);
        i_way = i_hit ? i_hit_way : (i_free ? i_free_way : i_oldest);
        d_old = d_st[idx][d_way];
    end

    // MESI next state and bus action
    always_comb
    begin
        lk_resp = '{op: req_q.op, hit: 1'b0, way: 3'd0, l2_op: L2_NONE};
        d_new   = d_old;
        d_wr    = 1'b0;
        d_fill  = 1'b0;
        i_fill  = 1'b0;
        case (req_q.op)
            OP_DREAD, OP_DWRITE:
            begin
                lk_resp.hit = d_hit;
                lk_resp.way = 3'(d_way);
                d_wr        = 1'b1;
                d_fill      = !d_hit;
                if (req_q.op == OP_DWRITE)
                begin
                    d_new = ST_M;
                    if (d_hit)
                        lk_resp.l2_op = (d_old == ST_S) ? L2_RFO : L2_NONE;
                    else
                        lk_resp.l2_op = (d_old == ST_M) ? L2_WB_RFO : L2_RFO;
                end
                else if (!d_hit)
                begin
                    d_new         = ST_E;
                    lk_resp.l2_op = (d_old == ST_M) ? L2_WB_READ : L2_READ;
                end
            end
            OP_IFETCH:
            begin
                lk_resp.hit = i_hit;
                lk_resp.way = 3'(i_way);
                i_fill      = !i_hit;
                if (!i_hit)
                    lk_resp.l2_op = L2_READ;
            end
            OP_SNOOP_INV, OP_SNOOP_RD:
            begin
                if (d_hit)
                begin
                    lk_resp.hit   = 1'b1;
                    lk_resp.way   = 3'(d_way);
                    lk_resp.l2_op = (d_old == ST_M) ? L2_RETURN : L2_NONE;
                    d_wr          = 1'b1;
                    if (req_q.op == OP_SNOOP_INV)
                        d_new = ST_I;
                    else if (d_old == ST_M || d_old == ST_E)
                        d_new = ST_S;
                end
            end
            default: ;      // clear answers from the walk
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= IDLE;
            clr_idx <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (not_empty)
                        state <= (head.op == OP_CLEAR) ? CLEAR : LOOKUP;
                end
                LOOKUP:  state <= UPDATE;
                UPDATE:  state <= IDLE;
                default:
                begin
                    clr_idx <= clr_idx + 1'b1;      // wraps back to 0
                    if (clr_idx == '1)
                        state <= UPDATE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            req_q <= head;
        if (pop && head.op == OP_CLEAR)
            resp <= '{op: OP_CLEAR, hit: 1'b0, way: 3'd0, l2_op: L2_NONE};
        else if (state == LOOKUP)
            resp <= lk_resp;
        if (upd && d_fill)
            d_tag[idx][d_way] <= tag;
        if (upd && i_fill)
            i_tag[idx][i_way] <= tag;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < D_WAYS; w++)
                    d_st[s][w] <= ST_I;
                for (int w = 0; w < I_WAYS; w++)
                    i_st[s][w] <= ST_I;
            end
        end
        else if (state == CLEAR)
        begin
            for (int w = 0; w < D_WAYS; w++)
                d_st[clr_idx][w] <= ST_I;
            for (int w = 0; w < I_WAYS; w++)
                i_st[clr_idx][w] <= ST_I;
        end
        else if (upd)
        begin
            if (d_wr)
                d_st[idx][d_way] <= d_new;
            if (i_fill)
                i_st[idx][i_way] <= ST_S;
        end
    end

    set_lru #(.WAYS(D_WAYS), .INDEX_W(INDEX_W)) u_d_lru (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (idx),
        .touch      (upd && (req_q.op == OP_DREAD || req_q.op == OP_DWRITE)),
        .touch_way  (d_way),
        .clear      (clr_start),
        .oldest_way (d_oldest)
    );

    set_lru #(.WAYS(I_WAYS), .INDEX_W(INDEX_W)) u_i_lru (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (idx),
        .touch      (upd && (req_q.op == OP_IFETCH)),
        .touch_way  (i_way),
        .clear      (clr_start),
        .oldest_way (i_oldest)
    );

    cache_stats u_stats (
        .clk    (clk),
        .arst_n (arst_n),
        .count  (upd),
        .op     (req_q.op),
        .hit    (lk_resp.hit),
        .clear  (clr_start),
        .stats  (stats)
    );

endmodule

/* logic/cache_pkg.sv */
// shared opcodes, MESI states, L2 bus operations and request/response structs
// imported by every stage of the L1 split cache and by its testbench
package cache_pkg;

    parameter int ADDR_W = 32;      // trace address width

    // decoded trace commands
    typedef enum logic [2:0]
    {
        OP_DREAD    = 3'd0,
        OP_DWRITE   = 3'd1,
        OP_IFETCH   = 3'd2,
        OP_SNOOP_INV = 3'd3,
        OP_SNOOP_RD = 3'd4,
        OP_CLEAR    = 3'd5
    } cache_op_e;

    typedef enum logic [1:0]
    {
        ST_I = 2'd0,
        ST_S = 2'd1,
        ST_E = 2'd2,
        ST_M = 2'd3
    } mesi_e;

    // action on the L2 bus
    typedef enum logic [2:0]
    {
        L2_NONE    = 3'd0,
        L2_READ    = 3'd1,
        L2_RFO     = 3'd2,
        L2_WB_READ = 3'd3,      // evict M victim, then read
        L2_WB_RFO  = 3'd4,
        L2_RETURN  = 3'd5       // modified data back to snooper
    } l2_op_e;

    typedef struct packed {
        cache_op_e          op;
        logic [ADDR_W-1:0]  addr;
    } cache_req_t;

    typedef struct packed {
        cache_op_e  op;
        logic       hit;
        logic [2:0] way;        // wide enough for the data cache
        l2_op_e     l2_op;
    } access_resp_t;

    typedef struct packed {
        logic [15:0] d_reads;
        logic [15:0] d_writes;
        logic [15:0] d_hits;
        logic [15:0] d_misses;
        logic [15:0] i_reads;
        logic [15:0] i_hits;
        logic [15:0] i_misses;
    } cache_stats_t;

endpackage

/* logic/cache_stats.sv */
`timescale 1ns/10ps
// saturating access counters for both caches, snoops are not counted
module cache_stats
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         count,
    input  cache_op_e    op,
    input  logic         hit,
    input  logic         clear,
    output cache_stats_t stats
);

    function automatic logic [15:0] sat_inc(input logic [15:0] v);
        return (v == 16'hffff) ? v : v + 16'd1;
    endfunction

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            stats <= '0;
        else if (clear)
            stats <= '0;
        else if (count)
        begin
            case (op)
                OP_DREAD, OP_DWRITE:
                begin
                    if (op == OP_DREAD)
                        stats.d_reads <= sat_inc(stats.d_reads);
                    else
                        stats.d_writes <= sat_inc(stats.d_writes);
                    if (hit)
                        stats.d_hits <= sat_inc(stats.d_hits);
                    else
                        stats.d_misses <= sat_inc(stats.d_misses);
                end
                OP_IFETCH:
                begin
                    stats.i_reads <= sat_inc(stats.i_reads);
                    if (hit)
                        stats.i_hits <= sat_inc(stats.i_hits);
                    else
                        stats.i_misses <= sat_inc(stats.i_misses);
                end
                default: ;
            endcase
        end
    end

endmodule

/* logic/cmd_fifo.sv */
`timescale 1ns/10ps
// request queue between decoder and controller
// busy goes high early enough to cover a push still held in the decoder
module cmd_fifo
    import cache_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push,
    input  cache_req_t push_req,
    input  logic       pop,
    output cache_req_t head,
    output logic       not_empty,
    output logic       busy
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cache_req_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push   = push && (count != CNT_W'(FIFO_DEPTH));    // dropped when full
    assign do_pop    = pop && (count != '0);
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign count_nxt = count + CNT_W'(do_push) - CNT_W'(do_pop);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            busy   <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count_nxt;
            busy  <= (count_nxt >= CNT_W'(FIFO_DEPTH - 1));   // one push may be in flight
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_req;
    end

endmodule

/* logic/l1_split_cache.sv */
`timescale 1ns/10ps
// L1 split cache top: trace decoder, command FIFO and cache controller
// source must hold off strobes while busy is high
module l1_split_cache
    import cache_pkg::*;
#(
    parameter int OFFSET_W   = 6,   // 64-byte line
    parameter int INDEX_W    = 4,
    parameter int D_WAYS     = 8,
    parameter int I_WAYS     = 4,
    parameter int FIFO_DEPTH = 4
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  logic [3:0]        cmd_code,
    input  logic [ADDR_W-1:0] cmd_addr,
    output logic              busy,
    output logic              bad_cmd,
    output logic              resp_valid,
    output access_resp_t      resp,
    output cache_stats_t      stats
);

    logic       push;
    cache_req_t push_req;
    cache_req_t head;
    logic       not_empty;
    logic       pop;

    trace_decoder u_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_code  (cmd_code),
        .cmd_addr  (cmd_addr),
        .push      (push),
        .req       (push_req),
        .bad_cmd   (bad_cmd)
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_req  (push_req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .busy      (busy)
    );

    cache_controller #(
        .OFFSET_W (OFFSET_W),
        .INDEX_W  (INDEX_W),
        .D_WAYS   (D_WAYS),
        .I_WAYS   (I_WAYS)
    ) u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .head       (head),
        .not_empty  (not_empty),
        .pop        (pop),
        .resp_valid (resp_valid),
        .resp       (resp),
        .stats      (stats)
    );

endmodule

/* logic/set_lru.sv */
`timescale 1ns/10ps
// per-set way ages for one cache, age 0 is most recent
// reports the oldest way of the addressed set combinationally
module set_lru
#(
    parameter int WAYS    = 8,
    parameter int INDEX_W = 4
)
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [INDEX_W-1:0]      index,
    input  logic                    touch,
    input  logic [$clog2(WAYS)-1:0] touch_way,
    input  logic                    clear,
    output logic [$clog2(WAYS)-1:0] oldest_way
);

    localparam int SETS  = 2 ** INDEX_W;
    localparam int WAY_W = $clog2(WAYS);

    logic [WAY_W-1:0] age [SETS][WAYS];
    logic [WAY_W-1:0] touched_age;

    assign touched_age = age[index][touch_way];

    always_comb
    begin
        oldest_way = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (age[index][w] == WAY_W'(WAYS - 1))
                oldest_way = WAY_W'(w);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int s = 0; s < SETS; s++)
                for (int w = 0; w < WAYS; w++)
                    age[s][w] <= WAY_W'(w);     // way w starts at age w
        end
        else if (clear)
        begin
            for (int s = 0; s < SETS; s++)
                for (int w = 0; w < WAYS; w++)
                    age[s][w] <= WAY_W'(w);
        end
        else if (touch)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                if (WAY_W'(w) == touch_way)
                    age[index][w] <= '0;
                else if (age[index][w] < touched_age)
                    age[index][w] <= age[index][w] + 1'b1;   // only younger ways age
            end
        end
    end

endmodule

/* logic/trace_decoder.sv */
`timescale 1ns/10ps
// maps trace code strobes onto typed cache requests
// unknown codes give a one-cycle bad_cmd pulse instead of a push
module trace_decoder
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  logic [3:0]        cmd_code,
    input  logic [ADDR_W-1:0] cmd_addr,
    output logic              push,
    output cache_req_t        req,
    output logic              bad_cmd
);

    cache_op_e op;
    logic      known;

    always_comb
    begin
        known = 1'b1;
        op    = OP_DREAD;
        case (cmd_code)
            4'd0:    op = OP_DREAD;
            4'd1:    op = OP_DWRITE;
            4'd2:    op = OP_IFETCH;
            4'd3:    op = OP_SNOOP_INV;
            4'd4:    op = OP_SNOOP_RD;
            4'd8:    op = OP_CLEAR;
            default: known = 1'b0;      // includes code 9
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            push    <= 1'b0;
            bad_cmd <= 1'b0;
        end
        else
        begin
            push    <= cmd_valid && known;
            bad_cmd <= cmd_valid && !known;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_valid && known)
            req <= '{op: op, addr: cmd_addr};
    end

endmodule

/* tb.f */
+incdir+dv
logic/cache_pkg.sv
logic/trace_decoder.sv
logic/cmd_fifo.sv
logic/set_lru.sv
logic/cache_stats.sv
logic/cache_controller.sv
logic/l1_split_cache.sv
dv/tb_l1_split_cache.sv
